// ==== rvPkg.sv ====
package rvPkg;

    // Datapath widths
    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // Instruction, data, address and PC word
    typedef logic [xlen-1:0] word_t;
    // Register index
    typedef logic [regAddrW-1:0] regAddr_t;

    // Data RAM depth in words
    localparam int dmemWords = 256;
    // First PC out of reset
    localparam word_t resetPc = '0;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011,
        opSystem = 7'b1110011
    } opcode_e;

    // Low three bits follow funct3, bit 3 is the funct7[5] variant
    typedef enum logic [3:0] {
        aluAdd   = 4'b0000,
        aluSll   = 4'b0001,
        aluSlt   = 4'b0010,
        aluSltu  = 4'b0011,
        aluXor   = 4'b0100,
        aluSrl   = 4'b0101,
        aluOr    = 4'b0110,
        aluAnd   = 4'b0111,
        aluSub   = 4'b1000,
        aluSra   = 4'b1101,
        aluPassB = 4'b1111
    } aluOp_e;

    // Immediate layouts
    typedef enum logic [2:0] {
        fmtI = 3'd0,
        fmtS = 3'd1,
        fmtB = 3'd2,
        fmtU = 3'd3,
        fmtJ = 3'd4
    } immFmt_e;

    // Write-back source
    typedef enum logic [1:0] {
        wbAlu     = 2'd0,
        wbMem     = 2'd1,
        wbPcPlus4 = 2'd2
    } wbSrc_e;

endpackage

// ==== instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  logic             clk,
    input  logic             rst,
    input  logic             instrValid,
    input  rvPkg::word_t     instr,
    output rvPkg::regAddr_t  rs1,
    output rvPkg::regAddr_t  rs2,
    output rvPkg::regAddr_t  rd,
    output logic [2:0]       funct3,
    output rvPkg::opcode_e   opcode,
    output rvPkg::aluOp_e    aluOp,
    output rvPkg::immFmt_e   immFmt,
    output rvPkg::wbSrc_e    wbSel,
    output logic             regWrite,
    output logic             memWrite,
    output logic             aluSrcImm,
    output logic             aluSrcPc,
    output logic             isBranch,
    output logic             isJal,
    output logic             isJalr,
    output logic             execValid,
    output logic             illegal,
    output rvPkg::word_t     instrQ
);

    import rvPkg::*;

    // funct7[5] picks SUB and SRA
    logic   altOp;
    aluOp_e aluFunct;

    // Decode register, empty slot after reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            execValid <= 1'b0;
            instrQ    <= '0;
        end
        else
        begin
            execValid <= instrValid;
            // Word only loaded on a strobe, the valid bit marks bubbles
            if (instrValid)
            begin
                instrQ <= instr;
            end
        end
    end

    // Fixed field positions
    assign opcode = opcode_e'(instrQ[6:0]);
    assign rd     = instrQ[11:7];
    assign funct3 = instrQ[14:12];
    assign rs1    = instrQ[19:15];
    assign rs2    = instrQ[24:20];

    // SUB only exists for register ops, SRAI and SRA share funct3 101
    assign altOp    = instrQ[30] && ((funct3 == 3'b101) ||
                                     (opcode == opReg && funct3 == 3'b000));
    assign aluFunct = aluOp_e'({altOp, funct3});

    always_comb
    begin
        // No-operation levels
        aluOp     = aluAdd;
        immFmt    = fmtI;
        wbSel     = wbAlu;
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        aluSrcImm = 1'b0;
        aluSrcPc  = 1'b0;
        isBranch  = 1'b0;
        isJal     = 1'b0;
        isJalr    = 1'b0;
        illegal   = 1'b0;
        // Bubble keeps every level low
        if (execValid)
        begin
            case (opcode)
                opLui:
                begin
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    aluOp     = aluPassB;
                    immFmt    = fmtU;
                end
                opAuipc:
                begin
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    aluSrcPc  = 1'b1;
                    immFmt    = fmtU;
                end
                opJal:
                begin
                    regWrite = 1'b1;
                    wbSel    = wbPcPlus4;
                    isJal    = 1'b1;
                    immFmt   = fmtJ;
                end
                opJalr:
                begin
                    regWrite = 1'b1;
                    wbSel    = wbPcPlus4;
                    isJalr   = 1'b1;
                end
                opBranch:
                begin
                    isBranch = 1'b1;
                    immFmt   = fmtB;
                end
                opLoad:
                begin
                    regWrite  = 1'b1;
                    wbSel     = wbMem;
                    aluSrcImm = 1'b1;
                end
                opStore:
                begin
                    memWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    immFmt    = fmtS;
                end
                opImm:
                begin
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    aluOp     = aluFunct;
                end
                opReg:
                begin
                    regWrite = 1'b1;
                    aluOp    = aluFunct;
                end
                // SYSTEM, FENCE and anything unknown
                default:
                begin
                    illegal = 1'b1;
                end
            endcase
        end
    end

    // A slot never both writes a register and stores
    assert property (@(posedge clk) disable iff (rst) !(regWrite && memWrite))
        else $error("regWrite and memWrite high together");

    // Bubbles drive no side effects and no illegal flag
    assert property (@(posedge clk) disable iff (rst)
        !execValid |-> !(regWrite || memWrite || isBranch || isJal || isJalr || illegal))
        else $error("enable high on a bubble");

endmodule

// ==== immGen.sv ====
`timescale 1ns/1ps

module immGen (
    input  rvPkg::word_t    instrQ,
    input  rvPkg::immFmt_e  immFmt,
    output rvPkg::word_t    imm
);

    import rvPkg::*;

    // Sign bit is always instruction bit 31
    logic sign;

    assign sign = instrQ[31];

    always_comb
    begin
        case (immFmt)
            // Stores split the offset around rd
            fmtS:
                imm = {{20{sign}}, instrQ[31:25], instrQ[11:7]};
            // Branch offset, halfword granular
            fmtB:
                imm = {{19{sign}}, instrQ[31], instrQ[7], instrQ[30:25],
                       instrQ[11:8], 1'b0};
            // Upper 20 bits, low part zero
            fmtU:
                imm = {instrQ[31:12], 12'b0};
            // JAL offset, scrambled 20 bits
            fmtJ:
                imm = {{11{sign}}, instrQ[31], instrQ[19:12], instrQ[20],
                       instrQ[30:21], 1'b0};
            // I format, also the fallback
            default:
                imm = {{20{sign}}, instrQ[31:20]};
        endcase
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  rvPkg::regAddr_t  rs1,
    input  rvPkg::regAddr_t  rs2,
    input  rvPkg::regAddr_t  rd,
    input  logic             wrEn,
    input  rvPkg::word_t     wrData,
    output rvPkg::word_t     rdData1,
    output rvPkg::word_t     rdData2
);

    import rvPkg::*;

    word_t regs [0:(1 << regAddrW)-1];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < (1 << regAddrW); i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn && rd != '0)
        begin
            regs[rd] <= wrData;
        end
    end

    // Asynchronous read ports
    assign rdData1 = regs[rs1];
    assign rdData2 = regs[rs2];

    // Zero register holds across every write
    assert property (@(posedge clk) disable iff (rst) rs1 == '0 |-> rdData1 == '0)
        else $error("x0 read returned non-zero");

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rvPkg::word_t    opA,
    input  rvPkg::word_t    opB,
    input  rvPkg::aluOp_e   aluOp,
    output rvPkg::word_t    result
);

    import rvPkg::*;

    // Shift distance from the low five bits
    logic [4:0] shamt;

    assign shamt = opB[4:0];

    always_comb
    begin
        case (aluOp)
            aluAdd:
                result = opA + opB;
            aluSub:
                result = opA - opB;
            aluSll:
                result = opA << shamt;
            // Compares yield 0 or 1
            aluSlt:
                result = word_t'($signed(opA) < $signed(opB));
            aluSltu:
                result = word_t'(opA < opB);
            aluXor:
                result = opA ^ opB;
            aluSrl:
                result = opA >> shamt;
            // Arithmetic shift keeps the sign
            aluSra:
                result = word_t'($signed(opA) >>> shamt);
            aluOr:
                result = opA | opB;
            aluAnd:
                result = opA & opB;
            // LUI route
            aluPassB:
                result = opB;
            default:
                result = '0;
        endcase
    end

endmodule

// ==== dataMem.sv ====
`timescale 1ns/1ps

module dataMem (
    input  logic          clk,
    input  rvPkg::word_t  addr,
    input  logic          wrEn,
    input  rvPkg::word_t  wrData,
    output rvPkg::word_t  rdData
);

    import rvPkg::*;

    word_t mem [0:dmemWords-1];
    logic [$clog2(dmemWords)-1:0] wordIdx;

    // Byte address to word index, upper bits dropped so it wraps
    assign wordIdx = addr[$clog2(dmemWords)+1:2];

    always_ff @(posedge clk)
    begin
        if (wrEn)
        begin
            mem[wordIdx] <= wrData;
        end
    end

    assign rdData = mem[wordIdx];

    // Word access only
    assert property (@(posedge clk) wrEn |-> addr[1:0] == 2'b00)
        else $error("misaligned store address %h", addr);

endmodule

// ==== pcUnit.sv ====
`timescale 1ns/1ps

module pcUnit (
    input  logic          clk,
    input  logic          rst,
    input  logic          execValid,
    input  logic          isBranch,
    input  logic          isJal,
    input  logic          isJalr,
    input  logic [2:0]    funct3,
    input  rvPkg::word_t  rsVal1,
    input  rvPkg::word_t  rsVal2,
    input  rvPkg::word_t  imm,
    output rvPkg::word_t  pc,
    output rvPkg::word_t  pcPlus4
);

    import rvPkg::*;

    logic  taken;
    word_t target;
    word_t pcNext;

    // Branch condition from funct3
    always_comb
    begin
        case (funct3)
            3'b000:  taken = (rsVal1 == rsVal2);
            3'b001:  taken = (rsVal1 != rsVal2);
            3'b100:  taken = ($signed(rsVal1) < $signed(rsVal2));
            3'b101:  taken = ($signed(rsVal1) >= $signed(rsVal2));
            3'b110:  taken = (rsVal1 < rsVal2);
            3'b111:  taken = (rsVal1 >= rsVal2);
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4 = pc + 32'd4;
    // JALR target drops bit 0
    assign target  = isJalr ? ((rsVal1 + imm) & ~word_t'(1)) : (pc + imm);
    assign pcNext  = (isJal || isJalr || (isBranch && taken)) ? target : pcPlus4;

    // Bubbles leave the PC in place
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pc <= resetPc;
        else if (execValid)
            pc <= pcNext;
    end

endmodule

// ==== rvCore.sv ====
`timescale 1ns/1ps

module rvCore (
    input  logic             clk,
    input  logic             rst,
    input  logic             instrValid,
    input  rvPkg::word_t     instr,
    output rvPkg::word_t     pc,
    output logic             wbValid,
    output rvPkg::regAddr_t  wbAddr,
    output rvPkg::word_t     wbData,
    output logic             illegal
);

    import rvPkg::*;

    // Decoder levels
    regAddr_t   rs1, rs2, rd;
    logic [2:0] funct3;
    aluOp_e     aluOp;
    immFmt_e    immFmt;
    wbSrc_e     wbSel;
    logic       regWrite, memWrite, aluSrcImm, aluSrcPc;
    logic       isBranch, isJal, isJalr, execValid;
    word_t      instrQ;

    // Datapath values
    word_t imm, rdData1, rdData2, opA, opB, aluResult, memRdData, pcPlus4;

    instrDecoder decoder_i (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
        .rs1(rs1), .rs2(rs2), .rd(rd), .funct3(funct3), .opcode(),
        .aluOp(aluOp), .immFmt(immFmt), .wbSel(wbSel),
        .regWrite(regWrite), .memWrite(memWrite),
        .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc),
        .isBranch(isBranch), .isJal(isJal), .isJalr(isJalr),
        .execValid(execValid), .illegal(illegal), .instrQ(instrQ)
    );

    immGen immGen_i (.instrQ(instrQ), .immFmt(immFmt), .imm(imm));

    regFile regFile_i (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
        .wrEn(wbValid), .wrData(wbData), .rdData1(rdData1), .rdData2(rdData2)
    );

    // Operand A is the PC for AUIPC, operand B the immediate for I/S/U
    assign opA = aluSrcPc  ? pc  : rdData1;
    assign opB = aluSrcImm ? imm : rdData2;

    alu alu_i (.opA(opA), .opB(opB), .aluOp(aluOp), .result(aluResult));

    // Store data always comes from rs2
    dataMem dataMem_i (
        .clk(clk), .addr(aluResult), .wrEn(memWrite), .wrData(rdData2), .rdData(memRdData)
    );

    pcUnit pcUnit_i (
        .clk(clk), .rst(rst), .execValid(execValid), .isBranch(isBranch),
        .isJal(isJal), .isJalr(isJalr), .funct3(funct3),
        .rsVal1(rdData1), .rsVal2(rdData2), .imm(imm),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    // Write-back port, x0 writes suppressed
    assign wbValid = regWrite && (rd != '0);
    assign wbAddr  = rd;
    assign wbData  = (wbSel == wbMem)     ? memRdData :
                     (wbSel == wbPcPlus4) ? pcPlus4   : aluResult;

endmodule

// ==== tbRvCore.sv ====
`timescale 1ns/1ps

module tbRvCore;

    import rvPkg::*;

    localparam int maxRows = 64;

    logic     clk;
    logic     rst;
    logic     instrValid;
    word_t    instr;
    word_t    pc;
    logic     wbValid;
    regAddr_t wbAddr;
    word_t    wbData;
    logic     illegal;

    // Stimulus and expected values, one row per cycle
    logic     rowValid [0:maxRows-1];
    word_t    rowInstr [0:maxRows-1];
    logic     expWbv   [0:maxRows-1];
    regAddr_t expWba   [0:maxRows-1];
    word_t    expWbd   [0:maxRows-1];
    word_t    expPc    [0:maxRows-1];
    logic     expIll   [0:maxRows-1];
    int       rowCount = 0;
    logic     tableReady = 1'b0;
    int       seed = 32'h19b9;

    rvCore dut_i (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
        .pc(pc), .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData), .illegal(illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Instruction encoders, arguments in assembly order
    function automatic word_t rType(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t iType(int opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t sType(int rs2, int rs1, int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic word_t bType(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t uType(int opc, int rd, int imm20);
        return {imm20[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t jType(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic addRow(logic v, word_t w, logic wbv, int wba, word_t wbd, word_t p, logic ill);
        rowValid[rowCount] = v;
        rowInstr[rowCount] = w;
        expWbv[rowCount]   = wbv;
        expWba[rowCount]   = regAddr_t'(wba);
        expWbd[rowCount]   = wbd;
        expPc[rowCount]    = p;
        expIll[rowCount]   = ill;
        rowCount++;
    endtask

    task automatic addInstr(word_t w, logic wbv, int wba, word_t wbd, word_t p, logic ill);
        addRow(1'b1, w, wbv, wba, wbd, p, ill);
    endtask

    // Random junk on instr, strobe low
    task automatic addBubble(word_t p);
        addRow(1'b0, $random(seed), 1'b0, 0, '0, p, 1'b0);
    endtask

    task automatic reportFail(string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic checkRow(int i);
        assert (illegal === expIll[i])
            else reportFail($sformatf("row %0d illegal got %b exp %b", i, illegal, expIll[i]));
        assert (pc === expPc[i])
            else reportFail($sformatf("row %0d pc got %h exp %h", i, pc, expPc[i]));
        assert (wbValid === expWbv[i])
            else reportFail($sformatf("row %0d wbValid got %b exp %b", i, wbValid, expWbv[i]));
        // Address and data only matter on a real write
        if (expWbv[i])
        begin
            assert (wbAddr === expWba[i])
                else reportFail($sformatf("row %0d wbAddr got %0d exp %0d", i, wbAddr, expWba[i]));
            assert (wbData === expWbd[i])
                else reportFail($sformatf("row %0d wbData got %h exp %h", i, wbData, expWbd[i]));
        end
    endtask

    initial
    begin
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;

        // Bubbles right after reset
        repeat (3) addBubble(32'd0);
        // Constants, negative immediate
        addInstr(uType(opLui, 1, 'h12345), 1, 1, 32'h12345000, 32'd0, 0);
        addInstr(iType(opImm, 0, 1, 1, 'h678), 1, 1, 32'h12345678, 32'd4, 0);
        addInstr(iType(opImm, 0, 2, 0, -5), 1, 2, 32'hFFFFFFFB, 32'd8, 0);
        // Register ops on x1 and x2
        addInstr(rType(0, 0, 3, 1, 2), 1, 3, 32'h12345673, 32'd12, 0);
        addInstr(rType(32, 0, 4, 1, 2), 1, 4, 32'h1234567D, 32'd16, 0);
        addInstr(rType(0, 7, 5, 1, 2), 1, 5, 32'h12345678, 32'd20, 0);
        addInstr(rType(0, 6, 6, 1, 2), 1, 6, 32'hFFFFFFFB, 32'd24, 0);
        addInstr(rType(0, 4, 7, 1, 2), 1, 7, 32'hEDCBA983, 32'd28, 0);
        addInstr(iType(opImm, 0, 8, 0, 4), 1, 8, 32'h00000004, 32'd32, 0);
        // Shifts and compares, x8 is the shift distance
        addInstr(rType(0, 1, 9, 1, 8), 1, 9, 32'h23456780, 32'd36, 0);
        addInstr(rType(0, 5, 10, 2, 8), 1, 10, 32'h0FFFFFFF, 32'd40, 0);
        addInstr(rType(32, 5, 11, 2, 8), 1, 11, 32'hFFFFFFFF, 32'd44, 0);
        addInstr(rType(0, 2, 12, 2, 8), 1, 12, 32'h00000001, 32'd48, 0);
        addInstr(rType(0, 3, 13, 2, 8), 1, 13, 32'h00000000, 32'd52, 0);
        addInstr(iType(opImm, 1, 14, 1, 8), 1, 14, 32'h34567800, 32'd56, 0);
        addInstr(iType(opImm, 5, 15, 2, 28), 1, 15, 32'h0000000F, 32'd60, 0);
        addInstr(iType(opImm, 5, 16, 2, 'h401), 1, 16, 32'hFFFFFFFD, 32'd64, 0);
        // x0 as target, then as source
        addInstr(rType(0, 0, 0, 1, 2), 0, 0, '0, 32'd68, 0);
        addInstr(rType(0, 0, 17, 0, 1), 1, 17, 32'h12345678, 32'd72, 0);
        addBubble(32'd76);
        // Two stores, two loads
        addInstr(sType(1, 0, 16), 0, 0, '0, 32'd76, 0);
        addInstr(sType(2, 8, 20), 0, 0, '0, 32'd80, 0);
        addInstr(iType(opLoad, 2, 18, 0, 16), 1, 18, 32'h12345678, 32'd84, 0);
        addInstr(iType(opLoad, 2, 19, 8, 20), 1, 19, 32'hFFFFFFFB, 32'd88, 0);
        // Branches, next row shows where each went
        addInstr(bType(0, 1, 17, 8), 0, 0, '0, 32'd92, 0);
        addInstr(bType(1, 1, 17, 8), 0, 0, '0, 32'd100, 0);
        addInstr(bType(4, 2, 8, 12), 0, 0, '0, 32'd104, 0);
        addInstr(bType(5, 2, 8, 8), 0, 0, '0, 32'd116, 0);
        addInstr(bType(6, 2, 8, 8), 0, 0, '0, 32'd120, 0);
        addInstr(bType(7, 2, 8, 8), 0, 0, '0, 32'd124, 0);
        addInstr(bType(1, 8, 0, -12), 0, 0, '0, 32'd132, 0);
        // Jumps, JALR target 4+33 lands on 36
        addInstr(jType(20, 16), 1, 20, 32'd124, 32'd120, 0);
        addInstr(iType(opJalr, 0, 21, 8, 33), 1, 21, 32'd140, 32'd136, 0);
        addInstr(uType(opAuipc, 22, 1), 1, 22, 32'h00001024, 32'd36, 0);
        // ECALL and FENCE are not supported
        addInstr(32'h00000073, 0, 0, '0, 32'd40, 1);
        addBubble(32'd44);
        // FENCE names x18 as rd, a stray write would change the ADD below
        addInstr(32'h0FF0090F, 0, 0, '0, 32'd44, 1);
        addInstr(rType(0, 0, 23, 18, 19), 1, 23, 32'h12345673, 32'd48, 0);
        // Opposite direction for each branch type
        addInstr(bType(0, 1, 2, 8), 0, 0, '0, 32'd52, 0);
        addInstr(bType(4, 8, 2, 8), 0, 0, '0, 32'd56, 0);
        addInstr(bType(5, 8, 2, 8), 0, 0, '0, 32'd60, 0);
        addInstr(bType(6, 8, 2, 8), 0, 0, '0, 32'd68, 0);
        addInstr(bType(7, 8, 2, 8), 0, 0, '0, 32'd76, 0);
        addBubble(32'd80);
        tableReady = 1'b1;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < rowCount; i++)
        begin
            instrValid = rowValid[i];
            instr      = rowInstr[i];
            @(posedge clk);
            @(negedge clk);
            checkRow(i);
        end
        instrValid = 1'b0;

        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog, sized from the table length
    initial
    begin
        wait (tableReady);
        #((rowCount + 20) * 10);
        $display("Timeout: the test did not complete within %0d cycles", rowCount + 20);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== build.f ====
rvPkg.sv
instrDecoder.sv
immGen.sv
regFile.sv
alu.sv
dataMem.sv
pcUnit.sv
rvCore.sv
tbRvCore.sv
